// File: hw/ibuf_pkg.sv
`default_nettype none

package ibuf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    // pc and instruction word
    localparam int XLEN    = 32;
    // branch type plus predicted pc
    localparam int BRPRE_W = 34;
    // exception code
    localparam int ECODE_W = 8;
    // one whole instruction as seen by the output muxes
    localparam int ENTRY_W = XLEN + XLEN + BRPRE_W + ECODE_W;

    ////////////////////////////////////////////////////////////////////////////
    // queue geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int DEPTH       = 16;
    // pointers wrap naturally, DEPTH is a power of two
    localparam int PTR_W       = 4;
    // count runs 0..DEPTH, so one bit more than the pointers
    localparam int CNT_W       = 5;
    // room left for pairs already in flight from fetch
    localparam int FULL_MARGIN = 6;
    localparam int FULL_LEVEL  = DEPTH - FULL_MARGIN;

    ////////////////////////////////////////////////////////////////////////////
    // output source selects
    ////////////////////////////////////////////////////////////////////////////

    localparam int SEL_W = 2;

    // oldest and next-oldest stored entry
    localparam logic [SEL_W-1:0] SRC_Q0  = 2'd0;
    localparam logic [SEL_W-1:0] SRC_Q1  = 2'd1;
    // incoming lanes of this cycle
    localparam logic [SEL_W-1:0] SRC_IN1 = 2'd2;
    localparam logic [SEL_W-1:0] SRC_IN2 = 2'd3;

    // lane-valid codes, any other value means nothing valid
    localparam logic [1:0] LANE_BOTH = 2'b11;
    localparam logic [1:0] LANE_ONE  = 2'b10;

endpackage

`default_nettype wire

// File: hw/ibuf_ctrl.sv
`default_nettype none

module ibuf_ctrl
    import ibuf_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  logic [1:0]       i_valid,
    input  logic             i_stall,
    input  logic             i_flush,
    output logic             o_wr_en0,
    output logic             o_wr_en1,
    output logic             o_wr_skip,
    output logic [PTR_W-1:0] o_wr_addr0,
    output logic [PTR_W-1:0] o_wr_addr1,
    output logic [PTR_W-1:0] o_rd_addr0,
    output logic [PTR_W-1:0] o_rd_addr1,
    output logic [SEL_W-1:0] o_sel1,
    output logic [SEL_W-1:0] o_sel2,
    output logic             o_load,
    output logic [1:0]       o_out_valid,
    output logic             o_full
);

    // head is the next write slot, tail the oldest stored entry
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [1:0]       n_in;
    logic [CNT_W-1:0] avail;
    logic [1:0]       n_deliv;
    logic [1:0]       q_share;
    logic [1:0]       in_share;
    logic [1:0]       take_q;
    logic [1:0]       take_in;
    logic [1:0]       n_store;
    logic             go;

    // does the named source hold an instruction this cycle
    function automatic logic src_exists(
        input logic [SEL_W-1:0] sel,
        input logic [CNT_W-1:0] stored,
        input logic [1:0]       incoming
    );
        case (sel)
            SRC_Q0:  src_exists = (stored >= CNT_W'(1));
            SRC_Q1:  src_exists = (stored >= CNT_W'(2));
            SRC_IN1: src_exists = (incoming >= 2'd1);
            default: src_exists = (incoming == 2'd2);
        endcase
    endfunction

    // flush wins over stall
    assign go = !i_stall && !i_flush;

    // incoming count from the lane code
    always_comb begin
        case (i_valid)
            LANE_BOTH: n_in = 2'd2;
            LANE_ONE:  n_in = 2'd1;
            default:   n_in = 2'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ordering split
    ////////////////////////////////////////////////////////////////////////////

    // at most two go to decode, oldest first
    assign avail    = count + CNT_W'(n_in);
    assign n_deliv  = (avail >= CNT_W'(2)) ? 2'd2 : avail[1:0];
    // queue comes first, lanes fill what is left
    assign q_share  = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];
    assign in_share = n_deliv - q_share;

    // stall delivers nothing, so every lane is stored
    assign take_q   = go ? q_share : 2'd0;
    assign take_in  = go ? in_share : 2'd0;
    // flushed inputs are dropped
    assign n_store  = i_flush ? 2'd0 : (n_in - take_in);

    // write steering
    assign o_wr_en0   = (n_store != 2'd0);
    assign o_wr_en1   = (n_store == 2'd2);
    // lane 1 went out, lane 2 lands on port 0
    assign o_wr_skip  = (take_in == 2'd1);
    assign o_wr_addr0 = head;
    assign o_wr_addr1 = head + PTR_W'(1);
    assign o_rd_addr0 = tail;
    assign o_rd_addr1 = tail + PTR_W'(1);

    // slot 1 takes the oldest, slot 2 the one after it
    assign o_sel1 = (count != '0) ? SRC_Q0 : SRC_IN1;
    assign o_sel2 = (count >= CNT_W'(2)) ? SRC_Q1 :
                    (count == CNT_W'(1)) ? SRC_IN1 : SRC_IN2;

    // nothing to hand over keeps the old data
    assign o_load      = go && (n_deliv != 2'd0);
    assign o_out_valid = (n_deliv == 2'd2) ? LANE_BOTH :
                         (n_deliv == 2'd1) ? LANE_ONE  : 2'b00;

    ////////////////////////////////////////////////////////////////////////////
    // pointers, count, almost full
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            o_full <= 1'b0;
        end else begin
            // looks at the count held before this edge
            o_full <= (count >= CNT_W'(FULL_LEVEL));
            if (i_flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                head  <= head + PTR_W'(n_store);
                tail  <= tail + PTR_W'(take_q);
                count <= count + CNT_W'(n_store) - CNT_W'(take_q);
            end
        end
    end

    // fetch ignored o_full long enough to overrun the queue
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        (count + CNT_W'(n_store) - CNT_W'(take_q)) <= CNT_W'(DEPTH));

    // output muxes never pick an empty source
    a_sel_valid: assert property (@(posedge clk) disable iff (!rstn)
        o_load |-> (src_exists(o_sel1, count, n_in) &&
                    ((n_deliv != 2'd2) || src_exists(o_sel2, count, n_in))));

endmodule

`default_nettype wire

// File: hw/ibuf_ram.sv
`default_nettype none

module ibuf_ram
    import ibuf_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_wr_en0,
    input  logic               i_wr_en1,
    input  logic               i_wr_skip,
    input  logic [PTR_W-1:0]   i_wr_addr0,
    input  logic [PTR_W-1:0]   i_wr_addr1,
    input  logic [PTR_W-1:0]   i_rd_addr0,
    input  logic [PTR_W-1:0]   i_rd_addr1,
    input  logic [XLEN-1:0]    i_pc1,
    input  logic [XLEN-1:0]    i_ir1,
    input  logic [BRPRE_W-1:0] i_brpre1,
    input  logic [ECODE_W-1:0] i_ecode1,
    input  logic [XLEN-1:0]    i_pc2,
    input  logic [XLEN-1:0]    i_ir2,
    input  logic [BRPRE_W-1:0] i_brpre2,
    input  logic [ECODE_W-1:0] i_ecode2,
    output logic [XLEN-1:0]    o_q0_pc,
    output logic [XLEN-1:0]    o_q0_ir,
    output logic [BRPRE_W-1:0] o_q0_brpre,
    output logic [ECODE_W-1:0] o_q0_ecode,
    output logic [XLEN-1:0]    o_q1_pc,
    output logic [XLEN-1:0]    o_q1_ir,
    output logic [BRPRE_W-1:0] o_q1_brpre,
    output logic [ECODE_W-1:0] o_q1_ecode
);

    // one array per field
    logic [XLEN-1:0]    pc_mem    [DEPTH];
    logic [XLEN-1:0]    ir_mem    [DEPTH];
    logic [BRPRE_W-1:0] brpre_mem [DEPTH];
    logic [ECODE_W-1:0] ecode_mem [DEPTH];

    // port 0 data, lane 2 when lane 1 was delivered
    logic [XLEN-1:0]    wr_pc0;
    logic [XLEN-1:0]    wr_ir0;
    logic [BRPRE_W-1:0] wr_brpre0;
    logic [ECODE_W-1:0] wr_ecode0;

    assign wr_pc0    = i_wr_skip ? i_pc2    : i_pc1;
    assign wr_ir0    = i_wr_skip ? i_ir2    : i_ir1;
    assign wr_brpre0 = i_wr_skip ? i_brpre2 : i_brpre1;
    assign wr_ecode0 = i_wr_skip ? i_ecode2 : i_ecode1;

    // port 1 only ever carries lane 2
    always_ff @(posedge clk) begin
        if (i_wr_en0) begin
            pc_mem[i_wr_addr0]    <= wr_pc0;
            ir_mem[i_wr_addr0]    <= wr_ir0;
            brpre_mem[i_wr_addr0] <= wr_brpre0;
            ecode_mem[i_wr_addr0] <= wr_ecode0;
        end
        if (i_wr_en1) begin
            pc_mem[i_wr_addr1]    <= i_pc2;
            ir_mem[i_wr_addr1]    <= i_ir2;
            brpre_mem[i_wr_addr1] <= i_brpre2;
            ecode_mem[i_wr_addr1] <= i_ecode2;
        end
    end

    // oldest two, read straight through
    assign o_q0_pc    = pc_mem[i_rd_addr0];
    assign o_q0_ir    = ir_mem[i_rd_addr0];
    assign o_q0_brpre = brpre_mem[i_rd_addr0];
    assign o_q0_ecode = ecode_mem[i_rd_addr0];
    assign o_q1_pc    = pc_mem[i_rd_addr1];
    assign o_q1_ir    = ir_mem[i_rd_addr1];
    assign o_q1_brpre = brpre_mem[i_rd_addr1];
    assign o_q1_ecode = ecode_mem[i_rd_addr1];

    // dual write must hit two slots, and never with lane 2 on both ports
    a_wr_distinct: assert property (@(posedge clk) disable iff (!rstn)
        (i_wr_en0 && i_wr_en1) |-> ((i_wr_addr0 != i_wr_addr1) && !i_wr_skip));

endmodule

`default_nettype wire

// File: hw/ibuf_out.sv
`default_nettype none

module ibuf_out
    import ibuf_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_load,
    input  logic [1:0]         i_out_valid,
    input  logic [SEL_W-1:0]   i_sel1,
    input  logic [SEL_W-1:0]   i_sel2,
    input  logic [XLEN-1:0]    i_q0_pc,
    input  logic [XLEN-1:0]    i_q0_ir,
    input  logic [BRPRE_W-1:0] i_q0_brpre,
    input  logic [ECODE_W-1:0] i_q0_ecode,
    input  logic [XLEN-1:0]    i_q1_pc,
    input  logic [XLEN-1:0]    i_q1_ir,
    input  logic [BRPRE_W-1:0] i_q1_brpre,
    input  logic [ECODE_W-1:0] i_q1_ecode,
    input  logic [XLEN-1:0]    i_pc1,
    input  logic [XLEN-1:0]    i_ir1,
    input  logic [BRPRE_W-1:0] i_brpre1,
    input  logic [ECODE_W-1:0] i_ecode1,
    input  logic [XLEN-1:0]    i_pc2,
    input  logic [XLEN-1:0]    i_ir2,
    input  logic [BRPRE_W-1:0] i_brpre2,
    input  logic [ECODE_W-1:0] i_ecode2,
    output logic [XLEN-1:0]    o_pc1,
    output logic [XLEN-1:0]    o_ir1,
    output logic [BRPRE_W-1:0] o_brpre1,
    output logic [ECODE_W-1:0] o_ecode1,
    output logic [XLEN-1:0]    o_pc2,
    output logic [XLEN-1:0]    o_ir2,
    output logic [BRPRE_W-1:0] o_brpre2,
    output logic [ECODE_W-1:0] o_ecode2,
    output logic [1:0]         o_valid
);

    // each source packed as pc, ir, brpre, ecode
    logic [ENTRY_W-1:0] src_q0;
    logic [ENTRY_W-1:0] src_q1;
    logic [ENTRY_W-1:0] src_in1;
    logic [ENTRY_W-1:0] src_in2;
    logic [ENTRY_W-1:0] slot1_d;
    logic [ENTRY_W-1:0] slot2_d;

    // same four-way pick for both slots
    function automatic logic [ENTRY_W-1:0] pick(
        input logic [SEL_W-1:0]   sel,
        input logic [ENTRY_W-1:0] q0,
        input logic [ENTRY_W-1:0] q1,
        input logic [ENTRY_W-1:0] in1,
        input logic [ENTRY_W-1:0] in2
    );
        case (sel)
            SRC_Q0:  pick = q0;
            SRC_Q1:  pick = q1;
            SRC_IN1: pick = in1;
            // SRC_IN2
            default: pick = in2;
        endcase
    endfunction

    assign src_q0  = {i_q0_pc, i_q0_ir, i_q0_brpre, i_q0_ecode};
    assign src_q1  = {i_q1_pc, i_q1_ir, i_q1_brpre, i_q1_ecode};
    assign src_in1 = {i_pc1, i_ir1, i_brpre1, i_ecode1};
    assign src_in2 = {i_pc2, i_ir2, i_brpre2, i_ecode2};

    assign slot1_d = pick(i_sel1, src_q0, src_q1, src_in1, src_in2);
    assign slot2_d = pick(i_sel2, src_q0, src_q1, src_in1, src_in2);

    ////////////////////////////////////////////////////////////////////////////
    // output register pair
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            {o_pc1, o_ir1, o_brpre1, o_ecode1} <= '0;
            {o_pc2, o_ir2, o_brpre2, o_ecode2} <= '0;
            o_valid <= 2'b00;
        end else if (i_load) begin
            {o_pc1, o_ir1, o_brpre1, o_ecode1} <= slot1_d;
            {o_pc2, o_ir2, o_brpre2, o_ecode2} <= slot2_d;
            o_valid <= i_out_valid;
        end else begin
            // stall, flush or empty: data holds, valid drops
            o_valid <= 2'b00;
        end
    end

endmodule

`default_nettype wire

// File: hw/ibuf_top.sv
`default_nettype none

module ibuf_top
    import ibuf_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    // fetch side, lane 1 is older
    input  logic [XLEN-1:0]    i_pc1,
    input  logic [XLEN-1:0]    i_ir1,
    input  logic [BRPRE_W-1:0] i_brpre1,
    input  logic [ECODE_W-1:0] i_ecode1,
    input  logic [XLEN-1:0]    i_pc2,
    input  logic [XLEN-1:0]    i_ir2,
    input  logic [BRPRE_W-1:0] i_brpre2,
    input  logic [ECODE_W-1:0] i_ecode2,
    input  logic [1:0]         i_valid,
    input  logic               i_stall,
    input  logic               i_flush,
    // decode side
    output logic [XLEN-1:0]    o_pc1,
    output logic [XLEN-1:0]    o_ir1,
    output logic [BRPRE_W-1:0] o_brpre1,
    output logic [ECODE_W-1:0] o_ecode1,
    output logic [XLEN-1:0]    o_pc2,
    output logic [XLEN-1:0]    o_ir2,
    output logic [BRPRE_W-1:0] o_brpre2,
    output logic [ECODE_W-1:0] o_ecode2,
    output logic [1:0]         o_valid,
    output logic               o_full
);

    // ctrl to storage
    logic             wr_en0;
    logic             wr_en1;
    logic             wr_skip;
    logic [PTR_W-1:0] wr_addr0;
    logic [PTR_W-1:0] wr_addr1;
    logic [PTR_W-1:0] rd_addr0;
    logic [PTR_W-1:0] rd_addr1;

    // ctrl to output stage
    logic [SEL_W-1:0] sel1;
    logic [SEL_W-1:0] sel2;
    logic             load;
    logic [1:0]       out_valid;

    // two oldest stored entries
    logic [XLEN-1:0]    q0_pc;
    logic [XLEN-1:0]    q0_ir;
    logic [BRPRE_W-1:0] q0_brpre;
    logic [ECODE_W-1:0] q0_ecode;
    logic [XLEN-1:0]    q1_pc;
    logic [XLEN-1:0]    q1_ir;
    logic [BRPRE_W-1:0] q1_brpre;
    logic [ECODE_W-1:0] q1_ecode;

    ibuf_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .i_valid(i_valid), .i_stall(i_stall), .i_flush(i_flush),
        .o_wr_en0(wr_en0), .o_wr_en1(wr_en1), .o_wr_skip(wr_skip),
        .o_wr_addr0(wr_addr0), .o_wr_addr1(wr_addr1),
        .o_rd_addr0(rd_addr0), .o_rd_addr1(rd_addr1),
        .o_sel1(sel1), .o_sel2(sel2), .o_load(load), .o_out_valid(out_valid),
        .o_full(o_full)
    );

    ibuf_ram u_ram (
        .clk(clk), .rstn(rstn), .i_wr_en0(wr_en0), .i_wr_en1(wr_en1), .i_wr_skip(wr_skip),
        .i_wr_addr0(wr_addr0), .i_wr_addr1(wr_addr1),
        .i_rd_addr0(rd_addr0), .i_rd_addr1(rd_addr1),
        .i_pc1(i_pc1), .i_ir1(i_ir1), .i_brpre1(i_brpre1), .i_ecode1(i_ecode1),
        .i_pc2(i_pc2), .i_ir2(i_ir2), .i_brpre2(i_brpre2), .i_ecode2(i_ecode2),
        .o_q0_pc(q0_pc), .o_q0_ir(q0_ir), .o_q0_brpre(q0_brpre), .o_q0_ecode(q0_ecode),
        .o_q1_pc(q1_pc), .o_q1_ir(q1_ir), .o_q1_brpre(q1_brpre), .o_q1_ecode(q1_ecode)
    );

    ibuf_out u_out (
        .clk(clk), .rstn(rstn), .i_load(load), .i_out_valid(out_valid),
        .i_sel1(sel1), .i_sel2(sel2),
        .i_q0_pc(q0_pc), .i_q0_ir(q0_ir), .i_q0_brpre(q0_brpre), .i_q0_ecode(q0_ecode),
        .i_q1_pc(q1_pc), .i_q1_ir(q1_ir), .i_q1_brpre(q1_brpre), .i_q1_ecode(q1_ecode),
        .i_pc1(i_pc1), .i_ir1(i_ir1), .i_brpre1(i_brpre1), .i_ecode1(i_ecode1),
        .i_pc2(i_pc2), .i_ir2(i_ir2), .i_brpre2(i_brpre2), .i_ecode2(i_ecode2),
        .o_pc1(o_pc1), .o_ir1(o_ir1), .o_brpre1(o_brpre1), .o_ecode1(o_ecode1),
        .o_pc2(o_pc2), .o_ir2(o_ir2), .o_brpre2(o_brpre2), .o_ecode2(o_ecode2),
        .o_valid(o_valid)
    );

endmodule

`default_nettype wire

// File: sim/tb_ibuf.sv
`default_nettype none

module tb_ibuf
    import ibuf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;

    // cycle budget of each test for the watchdog
    localparam int RESET_LEN   = 4;
    localparam int PASS_LEN    = 12;
    localparam int ODD_LEN     = 16;
    localparam int STALL_LEN   = 18;
    localparam int FLUSH_LEN   = 12;
    localparam int FULL_LEN    = 26;
    localparam int MARGIN_LEN  = 40;
    localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_LEN + PASS_LEN + ODD_LEN + STALL_LEN +
                                               FLUSH_LEN + FULL_LEN + MARGIN_LEN);

    logic               clk;
    logic               rstn;
    logic [XLEN-1:0]    i_pc1;
    logic [XLEN-1:0]    i_ir1;
    logic [BRPRE_W-1:0] i_brpre1;
    logic [ECODE_W-1:0] i_ecode1;
    logic [XLEN-1:0]    i_pc2;
    logic [XLEN-1:0]    i_ir2;
    logic [BRPRE_W-1:0] i_brpre2;
    logic [ECODE_W-1:0] i_ecode2;
    logic [1:0]         i_valid;
    logic               i_stall;
    logic               i_flush;
    logic [XLEN-1:0]    o_pc1;
    logic [XLEN-1:0]    o_ir1;
    logic [BRPRE_W-1:0] o_brpre1;
    logic [ECODE_W-1:0] o_ecode1;
    logic [XLEN-1:0]    o_pc2;
    logic [XLEN-1:0]    o_ir2;
    logic [BRPRE_W-1:0] o_brpre2;
    logic [ECODE_W-1:0] o_ecode2;
    logic [1:0]         o_valid;
    logic               o_full;

    int seed   = 32'hd30e_2b79;
    int errors = 0;
    int checks = 0;

    // reference queue of entries packed as pc, ir, brpre, ecode
    logic [ENTRY_W-1:0] model_q [$];
    logic [ENTRY_W-1:0] exp_slot1;
    logic [ENTRY_W-1:0] exp_slot2;
    // slot 2 data is don't-care after a single delivery
    logic               exp_slot2_known;
    logic [1:0]         exp_valid;
    logic               exp_full;

    ibuf_top u_dut (
        .clk(clk), .rstn(rstn),
        .i_pc1(i_pc1), .i_ir1(i_ir1), .i_brpre1(i_brpre1), .i_ecode1(i_ecode1),
        .i_pc2(i_pc2), .i_ir2(i_ir2), .i_brpre2(i_brpre2), .i_ecode2(i_ecode2),
        .i_valid(i_valid), .i_stall(i_stall), .i_flush(i_flush),
        .o_pc1(o_pc1), .o_ir1(o_ir1), .o_brpre1(o_brpre1), .o_ecode1(o_ecode1),
        .o_pc2(o_pc2), .o_ir2(o_ir2), .o_brpre2(o_brpre2), .o_ecode2(o_ecode2),
        .o_valid(o_valid), .o_full(o_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // field by field so the error names the port
    task automatic check_slot(input int slot, input logic [ENTRY_W-1:0] got,
                              input logic [ENTRY_W-1:0] exp);
        compare($sformatf("o_pc%0d", slot), 64'(got[ENTRY_W-1 -: XLEN]),
                64'(exp[ENTRY_W-1 -: XLEN]));
        compare($sformatf("o_ir%0d", slot), 64'(got[ENTRY_W-XLEN-1 -: XLEN]),
                64'(exp[ENTRY_W-XLEN-1 -: XLEN]));
        compare($sformatf("o_brpre%0d", slot), 64'(got[ECODE_W +: BRPRE_W]),
                64'(exp[ECODE_W +: BRPRE_W]));
        compare($sformatf("o_ecode%0d", slot), 64'(got[0 +: ECODE_W]),
                64'(exp[0 +: ECODE_W]));
    endtask

    task automatic check_outputs();
        compare("o_valid", 64'(o_valid), 64'(exp_valid));
        compare("o_full", 64'(o_full), 64'(exp_full));
        check_slot(1, {o_pc1, o_ir1, o_brpre1, o_ecode1}, exp_slot1);
        if (exp_slot2_known) begin
            check_slot(2, {o_pc2, o_ir2, o_brpre2, o_ecode2}, exp_slot2);
        end
    endtask

    task automatic random_entry(output logic [ENTRY_W-1:0] e);
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        e = r[ENTRY_W-1:0];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one cycle of driving at negedge and checking at the next negedge
    ////////////////////////////////////////////////////////////////////////////

    task automatic step(input logic [1:0] valid, input logic stall, input logic flush);
        logic [ENTRY_W-1:0] in1;
        logic [ENTRY_W-1:0] in2;
        int                 n;
        int                 k;
        random_entry(in1);
        random_entry(in2);
        {i_pc1, i_ir1, i_brpre1, i_ecode1} = in1;
        {i_pc2, i_ir2, i_brpre2, i_ecode2} = in2;
        i_valid = valid;
        i_stall = stall;
        i_flush = flush;
        n = (valid == LANE_BOTH) ? 2 : (valid == LANE_ONE) ? 1 : 0;
        // almost full looks at the count before this edge
        exp_full  = (model_q.size() >= FULL_LEVEL);
        exp_valid = 2'b00;
        if (flush) begin
            model_q.delete();
        end else begin
            // stored entries are older than lane 1, lane 1 older than lane 2
            if (n >= 1) model_q.push_back(in1);
            if (n == 2) model_q.push_back(in2);
            if (!stall) begin
                k = (model_q.size() >= 2) ? 2 : model_q.size();
                if (k >= 1) begin
                    exp_slot1       = model_q.pop_front();
                    exp_valid       = LANE_ONE;
                    exp_slot2_known = 1'b0;
                end
                if (k == 2) begin
                    exp_slot2       = model_q.pop_front();
                    exp_valid       = LANE_BOTH;
                    exp_slot2_known = 1'b1;
                end
            end
        end
        @(negedge clk);
        check_outputs();
    endtask

    // idle cycles until the model is empty plus one more
    task automatic drain();
        while (model_q.size() != 0) begin
            step(2'b00, 1'b0, 1'b0);
        end
        step(2'b00, 1'b0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        exp_slot1       = '0;
        exp_slot2       = '0;
        exp_slot2_known = 1'b1;
        exp_valid       = 2'b00;
        exp_full        = 1'b0;
        check_outputs();
    endtask

    task automatic test_pass_through();
        repeat (8) step(LANE_BOTH, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_odd_lanes();
        step(LANE_ONE, 1'b0, 1'b0);
        step(LANE_BOTH, 1'b0, 1'b0);
        step(2'b00, 1'b0, 1'b0);
        // code 01 carries nothing
        step(2'b01, 1'b0, 1'b0);
        // three stored, two leave and one stays behind
        step(LANE_BOTH, 1'b1, 1'b0);
        step(LANE_ONE, 1'b1, 1'b0);
        step(2'b00, 1'b0, 1'b0);
        // stored one plus lane 1 go out, lane 2 lands on write port 0
        step(LANE_BOTH, 1'b0, 1'b0);
        step(LANE_ONE, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_stall();
        step(LANE_BOTH, 1'b0, 1'b0);
        step(LANE_BOTH, 1'b0, 1'b0);
        repeat (3) step(LANE_BOTH, 1'b1, 1'b0);
        // stored pairs go first and new single lanes queue behind
        repeat (4) step(LANE_ONE, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_flush();
        step(LANE_BOTH, 1'b1, 1'b0);
        step(LANE_BOTH, 1'b1, 1'b0);
        step(LANE_BOTH, 1'b0, 1'b1);
        // flush beats stall
        step(LANE_BOTH, 1'b1, 1'b1);
        step(LANE_ONE, 1'b0, 1'b0);
        step(LANE_BOTH, 1'b0, 1'b0);
        drain();
    endtask

    task automatic test_almost_full();
        repeat (7) step(LANE_BOTH, 1'b1, 1'b0);
        step(2'b00, 1'b1, 1'b0);
        compare("o_full", 64'(o_full), 64'(1'b1));
        drain();
        compare("o_full", 64'(o_full), 64'(1'b0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rstn    = 1'b0;
        i_pc1   = '0;
        i_ir1   = '0;
        i_brpre1 = '0;
        i_ecode1 = '0;
        i_pc2   = '0;
        i_ir2   = '0;
        i_brpre2 = '0;
        i_ecode2 = '0;
        i_valid = 2'b00;
        i_stall = 1'b0;
        i_flush = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_reset();
        test_pass_through();
        test_odd_lanes();
        test_stall();
        test_flush();
        test_almost_full();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/ibuf_pkg.sv
hw/ibuf_ctrl.sv
hw/ibuf_ram.sv
hw/ibuf_out.sv
hw/ibuf_top.sv
sim/tb_ibuf.sv

// File: Makefile
# Verilator build and run for the instruction buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_ibuf
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := Errors found

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
